// ==== verilog/matvec_pkg.sv ====
package matvec_pkg;

    // matrix columns, also the vector length
    localparam int lanes = 8;

    // matrix rows, one result per row
    localparam int rows = 8;

    // result buffer entries
    localparam int fifo_depth = 16;

    // signed operand word from the load port
    typedef logic signed [13:0] data_t;

    // signed row result, sums wrap modulo 2^28
    typedef logic signed [27:0] result_t;

    // row index into a column bank
    typedef logic [2:0] row_t;

    // one strobe bit per lane
    typedef logic [7:0] lane_mask_t;

    // word position within a load, 0 to 63
    typedef logic [5:0] word_count_t;

    // buffer slot count, 0 to 16 inclusive
    typedef logic [4:0] slot_count_t;

    // load and compute phases of the sequencer
    typedef enum logic [1:0] {
        load_matrix,
        load_vector,
        wait_space,
        compute
    } seq_state_t;

endpackage

// ==== verilog/bank_write_if.sv ====
`timescale 1ns/1ps

interface bank_write_if;
    import matvec_pkg::*;

    // word being written, shared by every lane
    data_t      data;
    // target row, only meaningful for matrix words
    row_t       row;
    // one-hot lane strobes, at most one bit set across both masks
    lane_mask_t matrix_we;
    lane_mask_t vector_we;

    modport sequencer (
        output data,
        output row,
        output matrix_we,
        output vector_we
    );

    modport banks (
        input data,
        input row,
        input matrix_we,
        input vector_we
    );

endinterface

// ==== verilog/load_sequencer.sv ====
`timescale 1ns/1ps

module load_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    input_valid,
    input  logic                    new_matrix,
    input  matvec_pkg::data_t       input_data,
    output logic                    input_ready,
    input  matvec_pkg::slot_count_t free_slots,
    bank_write_if.sequencer         wr,
    output logic                    issue,
    output matvec_pkg::row_t        issue_row,
    output logic                    reserve
);
    import matvec_pkg::*;

    seq_state_t  state;
    word_count_t count;
    // held low for one cycle after reset
    logic        started;
    // next accepted word opens a new load
    logic        first_word;
    logic        accept;
    logic        matrix_phase;
    logic        room;

    // ready only while loading, and not right after reset
    assign input_ready = started && (state == load_matrix || state == load_vector);
    assign accept = input_valid && input_ready;

    // new_matrix only matters on the opening word of a load
    assign matrix_phase = (state == load_matrix) ||
                          (state == load_vector && first_word && new_matrix);

    // enough unreserved slots for a whole compute phase
    assign room = free_slots >= slot_count_t'(rows);

    // word k lands in lane k mod 8, row k div 8
    assign wr.data = input_data;
    // banks ignore the row for vector words
    assign wr.row = count[5:3];
    assign wr.matrix_we = (accept && matrix_phase) ? (lane_mask_t'(1) << count[2:0]) : '0;
    assign wr.vector_we = (accept && !matrix_phase) ? (lane_mask_t'(1) << count[2:0]) : '0;

    // one row per compute cycle, rows 0 to 7 in order
    assign issue = (state == compute);
    assign issue_row = count[2:0];
    // claim eight buffer slots on the first compute cycle
    assign reserve = (state == compute) && (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= load_vector;
            count <= '0;
            started <= 1'b0;
            first_word <= 1'b1;
        end else begin
            started <= 1'b1;
            case (state)
                load_matrix: begin
                    if (accept) begin
                        // last matrix word, vector follows
                        if (count == word_count_t'(lanes * rows - 1)) begin
                            state <= load_vector;
                            count <= '0;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                load_vector: begin
                    if (accept) begin
                        first_word <= 1'b0;
                        if (matrix_phase) begin
                            // opening word was matrix word 0
                            state <= load_matrix;
                            count <= count + 1'b1;
                        end else if (count == word_count_t'(lanes - 1)) begin
                            count <= '0;
                            state <= room ? compute : wait_space;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                wait_space: begin
                    // stalled until the buffer drains enough
                    if (room) begin
                        state <= compute;
                    end
                end
                compute: begin
                    if (count == word_count_t'(rows - 1)) begin
                        // earlier rows keep flowing while the next load starts
                        state <= load_vector;
                        count <= '0;
                        first_word <= 1'b1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    state <= load_vector;
                end
            endcase
        end
    end

endmodule

// ==== verilog/operand_banks.sv ====
`timescale 1ns/1ps

module operand_banks (
    input  logic              clk,
    bank_write_if.banks       wr,
    input  logic              issue,
    input  matvec_pkg::row_t  issue_row,
    output logic              operands_valid,
    output matvec_pkg::data_t matrix_row [matvec_pkg::lanes],
    output matvec_pkg::data_t vector [matvec_pkg::lanes]
);
    import matvec_pkg::*;

    // one column bank per lane, indexed by row
    data_t column_bank [lanes][rows];
    // live vector, overwritten by the next load
    data_t vector_reg [lanes];

    for (genvar l = 0; l < lanes; l++) begin : g_lane
        // private write port per lane
        always_ff @(posedge clk) begin
            if (wr.matrix_we[l]) begin
                column_bank[l][wr.row] <= wr.data;
            end
            if (wr.vector_we[l]) begin
                vector_reg[l] <= wr.data;
            end
        end
    end

    // valid follows issue by one cycle
    always_ff @(posedge clk) begin
        operands_valid <= issue;
    end

    // snapshot the row and the vector together
    // so a vector load in progress cannot disturb rows in flight
    always_ff @(posedge clk) begin
        if (issue) begin
            for (int l = 0; l < lanes; l++) begin
                matrix_row[l] <= column_bank[l][issue_row];
                vector[l] <= vector_reg[l];
            end
        end
    end

endmodule

// ==== verilog/dot_product_pipeline.sv ====
`timescale 1ns/1ps

module dot_product_pipeline (
    input  logic                clk,
    input  logic                reset,
    input  logic                operands_valid,
    input  matvec_pkg::data_t   matrix_row [matvec_pkg::lanes],
    input  matvec_pkg::data_t   vector [matvec_pkg::lanes],
    output logic                sum_valid,
    output matvec_pkg::result_t sum
);
    import matvec_pkg::*;

    // stage 1, lane products
    result_t product [lanes];
    // stage 2, pairwise sums
    result_t partial4 [lanes / 2];
    // stage 3
    result_t partial2 [lanes / 4];
    // valid for stages 1 to 3, sum_valid is stage 4
    logic [2:0] stage_valid;

    // valid bits shift alongside the data
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
            sum_valid <= 1'b0;
        end else begin
            stage_valid <= {stage_valid[1:0], operands_valid};
            sum_valid <= stage_valid[2];
        end
    end

    always_ff @(posedge clk) begin
        // 14 x 14 signed fits 28 bits exactly
        for (int i = 0; i < lanes; i++) begin
            product[i] <= result_t'(matrix_row[i]) * result_t'(vector[i]);
        end

        // 8 to 4, sums wrap at 28 bits
        for (int i = 0; i < lanes / 2; i++) begin
            partial4[i] <= product[2 * i] + product[2 * i + 1];
        end

        // 4 to 2
        for (int i = 0; i < lanes / 4; i++) begin
            partial2[i] <= partial4[2 * i] + partial4[2 * i + 1];
        end

        // 2 to 1
        sum <= partial2[0] + partial2[1];
    end

endmodule

// ==== verilog/result_fifo.sv ====
`timescale 1ns/1ps

module result_fifo (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    reserve,
    input  logic                    sum_valid,
    input  matvec_pkg::result_t     sum,
    input  logic                    output_ready,
    output logic                    output_valid,
    output matvec_pkg::result_t     output_data,
    output matvec_pkg::slot_count_t free_slots
);
    import matvec_pkg::*;

    result_t entries [fifo_depth];
    // pointers wrap naturally at the buffer depth
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    // entries currently held
    slot_count_t fill;
    logic pop;

    // head entry visible the cycle after its write
    assign output_valid = (fill != '0);
    assign output_data = entries[rd_ptr];
    assign pop = output_valid && output_ready;

    // reservation guarantees a free entry on every write
    always_ff @(posedge clk) begin
        if (sum_valid) begin
            entries[wr_ptr] <= sum;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
            free_slots <= slot_count_t'(fifo_depth);
        end else begin
            if (sum_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({sum_valid, pop})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: fill <= fill;
            endcase

            // credits leave in blocks of eight, return one per pop
            case ({reserve, pop})
                2'b10: free_slots <= free_slots - slot_count_t'(rows);
                2'b01: free_slots <= free_slots + 1'b1;
                2'b11: free_slots <= free_slots - slot_count_t'(rows - 1);
                default: free_slots <= free_slots;
            endcase
        end
    end

endmodule

// ==== verilog/matvec_top.sv ====
`timescale 1ns/1ps

module matvec_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                input_valid,
    output logic                input_ready,
    input  matvec_pkg::data_t   input_data,
    input  logic                new_matrix,
    output logic                output_valid,
    input  logic                output_ready,
    output matvec_pkg::result_t output_data
);
    import matvec_pkg::*;

    // sequencer to banks and buffer
    logic        issue;
    row_t        issue_row;
    logic        reserve;
    slot_count_t free_slots;
    // banks to multiplier tree
    logic        operands_valid;
    data_t       matrix_row [lanes];
    data_t       vector [lanes];
    // tree to result buffer
    logic        sum_valid;
    result_t     sum;

    // load words and lane strobes
    bank_write_if wr_bus ();

    load_sequencer load_sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .input_valid (input_valid),
        .new_matrix  (new_matrix),
        .input_data  (input_data),
        .input_ready (input_ready),
        .free_slots  (free_slots),
        .wr          (wr_bus.sequencer),
        .issue       (issue),
        .issue_row   (issue_row),
        .reserve     (reserve)
    );

    operand_banks operand_banks_i (
        .clk            (clk),
        .wr             (wr_bus.banks),
        .issue          (issue),
        .issue_row      (issue_row),
        .operands_valid (operands_valid),
        .matrix_row     (matrix_row),
        .vector         (vector)
    );

    dot_product_pipeline dot_product_pipeline_i (
        .clk            (clk),
        .reset          (reset),
        .operands_valid (operands_valid),
        .matrix_row     (matrix_row),
        .vector         (vector),
        .sum_valid      (sum_valid),
        .sum            (sum)
    );

    result_fifo result_fifo_i (
        .clk          (clk),
        .reset        (reset),
        .reserve      (reserve),
        .sum_valid    (sum_valid),
        .sum          (sum),
        .output_ready (output_ready),
        .output_valid (output_valid),
        .output_data  (output_data),
        .free_slots   (free_slots)
    );

endmodule

// ==== verification/matvec_tb.sv ====
`timescale 1ns/1ps

module matvec_tb;
    import matvec_pkg::*;

    localparam int num_tests = 7;
    localparam int timeout_cycles = 200;
    // observation window for a stalled load port
    localparam int hold_cycles = 20;

    logic    clk;
    logic    reset;
    logic    input_valid;
    logic    input_ready;
    data_t   input_data;
    logic    new_matrix;
    logic    output_valid;
    logic    output_ready;
    result_t output_data;

    // stimulus table, one entry per test
    logic       new_matrix_tab [num_tests];
    data_t      matrix_tab [num_tests][rows][lanes];
    data_t      vector_tab [num_tests][lanes];
    // output_ready on drain cycle n is bit n mod 8, all zero holds outputs back
    logic [7:0] stall_tab [num_tests];
    result_t    expected_tab [num_tests][rows];

    // results still owed by the DUT, oldest first
    result_t exp_q [$];
    int      checks;
    int      errors;
    logic    timed_out;
    int      seed_dummy;

    matvec_top matvec_top_i (
        .clk          (clk),
        .reset        (reset),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .input_data   (input_data),
        .new_matrix   (new_matrix),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .output_data  (output_data)
    );

    always #10 clk = ~clk;

    task automatic check_result(input string name, input result_t actual,
                                input result_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // fill the table and derive the expected row sums
    task automatic build_table();
        int     src;
        longint acc;
        src = 0;
        new_matrix_tab = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
        stall_tab = '{8'hff, 8'hb2, 8'hff, 8'h55, 8'h00, 8'h00, 8'hdb};
        for (int t = 0; t < num_tests; t++) begin
            for (int c = 0; c < lanes; c++) begin
                vector_tab[t][c] = data_t'($urandom);
                for (int r = 0; r < rows; r++) begin
                    matrix_tab[t][r][c] = data_t'($urandom);
                end
            end
        end
        // extreme operands, 14'sh1fff is the largest word and 14'sh2000 the smallest
        for (int c = 0; c < lanes; c++) begin
            vector_tab[2][c] = 14'sh2000;
            vector_tab[3][c] = (c % 2 == 0) ? 14'sh1fff : 14'sh2000;
            for (int r = 0; r < rows; r++) begin
                matrix_tab[2][r][c] = (c < r) ? 14'sh1fff : 14'sh2000;
            end
        end
        for (int t = 0; t < num_tests; t++) begin
            // vector-only loads reuse the last full matrix
            if (new_matrix_tab[t]) begin
                src = t;
            end
            for (int r = 0; r < rows; r++) begin
                acc = 0;
                for (int c = 0; c < lanes; c++) begin
                    matrix_tab[t][r][c] = matrix_tab[src][r][c];
                    acc += longint'(matrix_tab[t][r][c]) * longint'(vector_tab[t][c]);
                end
                // keep the low 28 bits
                expected_tab[t][r] = result_t'(acc);
            end
        end
    endtask

    // stream one load, valid gaps picked at random
    task automatic feed_load(input int t);
        int n_words;
        int w;
        int waited;
        n_words = new_matrix_tab[t] ? lanes * rows + lanes : lanes;
        w = 0;
        waited = 0;
        new_matrix = new_matrix_tab[t];
        output_ready = 1'b0;
        while (w < n_words && waited < timeout_cycles) begin
            if (new_matrix_tab[t] && w < lanes * rows) begin
                input_data = matrix_tab[t][w / lanes][w % lanes];
            end else if (new_matrix_tab[t]) begin
                input_data = vector_tab[t][w - lanes * rows];
            end else begin
                input_data = vector_tab[t][w];
            end
            input_valid = ($urandom_range(3) != 0);
            @(negedge clk);
            if (input_valid && input_ready) begin
                w++;
                waited = 0;
            end else begin
                waited++;
            end
            @(posedge clk);
            #2;
        end
        input_valid = 1'b0;
        if (w < n_words) begin
            errors++;
            timed_out = 1'b1;
            $display("test %0d: load port stopped accepting at word %0d", t, w);
        end
    endtask

    // buffer full, the load port must stay closed
    task automatic hold_check();
        output_ready = 1'b0;
        for (int i = 0; i < hold_cycles; i++) begin
            @(negedge clk);
            check_flag("input_ready", input_ready, 1'b0);
            @(posedge clk);
            #2;
        end
    endtask

    // pop every owed result under the test's stall pattern
    task automatic drain(input int t);
        int cycle;
        int waited;
        cycle = 0;
        waited = 0;
        while (exp_q.size() > 0 && waited < timeout_cycles) begin
            output_ready = stall_tab[t][cycle % 8];
            cycle++;
            @(negedge clk);
            if (output_valid && output_ready) begin
                check_result("output_data", output_data, exp_q.pop_front());
                waited = 0;
            end else begin
                waited++;
            end
            @(posedge clk);
            #2;
        end
        output_ready = 1'b0;
        if (exp_q.size() > 0) begin
            errors++;
            timed_out = 1'b1;
            $display("test %0d: %0d results never arrived", t, exp_q.size());
        end
        // nothing extra may follow
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_flag("output_valid", output_valid, 1'b0);
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        int   errors_before;
        int   checks_before;
        int   waited;
        int   tests_run;
        logic blocked;
        clk = 1'b0;
        reset = 1'b1;
        input_valid = 1'b0;
        input_data = '0;
        new_matrix = 1'b0;
        output_ready = 1'b0;
        checks = 0;
        errors = 0;
        tests_run = 0;
        timed_out = 1'b0;
        seed_dummy = $urandom(32'heff9);
        build_table();

        // both handshake outputs quiet during reset
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #2;
            check_flag("input_ready", input_ready, 1'b0);
            check_flag("output_valid", output_valid, 1'b0);
        end
        reset = 1'b0;
        @(negedge clk);
        check_flag("input_ready", input_ready, 1'b0);
        @(posedge clk);
        #2;
        waited = 0;
        while (!input_ready && waited < timeout_cycles) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!input_ready) begin
            errors++;
            timed_out = 1'b1;
            $display("input_ready never rose after reset");
        end

        for (int t = 0; t < num_tests && !timed_out; t++) begin
            errors_before = errors;
            checks_before = checks;
            // a compute phase needs eight unreserved slots
            blocked = (fifo_depth - exp_q.size()) < rows;
            feed_load(t);
            for (int r = 0; r < rows; r++) begin
                exp_q.push_back(expected_tab[t][r]);
            end
            if (blocked && !timed_out) begin
                hold_check();
            end
            if (stall_tab[t] != 8'h00 && !timed_out) begin
                drain(t);
            end
            tests_run++;
            $display("test %0d (%s, %s): %0d checks, %0d errors", t,
                     new_matrix_tab[t] ? "full load" : "vector load",
                     (stall_tab[t] == 8'h00) ? "held" : "drained",
                     checks - checks_before, errors - errors_before);
        end

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/matvec_pkg.sv
verilog/bank_write_if.sv
verilog/load_sequencer.sv
verilog/operand_banks.sv
verilog/dot_product_pipeline.sv
verilog/result_fifo.sv
verilog/matvec_top.sv
verification/matvec_tb.sv

// ==== Bender.yml ====
package:
  name: matvec

sources:
  - verilog/matvec_pkg.sv
  - verilog/bank_write_if.sv
  - verilog/load_sequencer.sv
  - verilog/operand_banks.sv
  - verilog/dot_product_pipeline.sv
  - verilog/result_fifo.sv
  - verilog/matvec_top.sv
  - target: test
    files:
      - verification/matvec_tb.sv
